// ==== logic/rv_ex_cfg.svh ====
`ifndef RV_EX_CFG_SVH
`define RV_EX_CFG_SVH

// data path
`define RV_XLEN 32
`define RV_REG_AW 5

// csr bank
`define RV_CSR_AW 12
`define RV_CSR_COUNT 4

`endif

// ==== logic/rv_ex_pkg.sv ====
`include "rv_ex_cfg.svh"

package rv_ex_pkg;

	// --------------------
	// vector types
	// --------------------
	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_REG_AW-1:0] reg_addr_t;
	typedef logic [`RV_CSR_AW-1:0] csr_addr_t;

	// --------------------
	// control encodings
	// --------------------
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_SLL   = 4'd2,
		ALU_SLT   = 4'd3,
		ALU_SLTU  = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SRA   = 4'd7,
		ALU_OR    = 4'd8,
		ALU_AND   = 4'd9,
		ALU_PASSB = 4'd10
	} alu_op_e;

	// writeback source, only carried to MEM
	typedef enum logic [1:0] {
		WB_MEM = 2'd0,
		WB_ALU = 2'd1,
		WB_PC4 = 2'd2,
		WB_CSR = 2'd3
	} wb_sel_e;

	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwd_sel_e;

endpackage

// ==== logic/ex_mem_if.sv ====
interface ex_mem_if;
	import rv_ex_pkg::*;

	word_t alu;
	word_t rs2;
	word_t pc4;
	logic mem_we;
	wb_sel_e wb_sel;
	logic reg_we;
	reg_addr_t rd;
	logic csr_we;
	csr_addr_t csr_addr;
	word_t csr_rdata;

	// owner of the EX/MEM register
	modport stage (
		output alu, rs2, pc4, mem_we, wb_sel, reg_we, rd,
		output csr_we, csr_addr, csr_rdata
	);

	// hazard compare
	modport fwd (
		input rd, reg_we
	);

	// csr commit from MEM
	modport csr (
		input csr_we, csr_addr, alu
	);

endinterface

// ==== logic/forward_unit.sv ====
module forward_unit (
	input rv_ex_pkg::reg_addr_t rs1_i,
	input rv_ex_pkg::reg_addr_t rs2_i,
	ex_mem_if.fwd mem,
	input rv_ex_pkg::reg_addr_t rd_wb_i,
	input logic reg_we_wb_i,
	output rv_ex_pkg::fwd_sel_e fwd_a_o,
	output rv_ex_pkg::fwd_sel_e fwd_b_o
);
	import rv_ex_pkg::*;

	logic mem_live;
	logic wb_live;

	// x0 is hardwired, never forward it
	assign mem_live = mem.reg_we && (mem.rd != '0);
	assign wb_live = reg_we_wb_i && (rd_wb_i != '0);

	function automatic fwd_sel_e pick_src(
		input reg_addr_t rs,
		input logic mem_hit_en,
		input reg_addr_t mem_rd,
		input logic wb_hit_en,
		input reg_addr_t wb_rd
	);
		fwd_sel_e sel;
		sel = FWD_NONE;
		// younger result wins
		if (mem_hit_en && (mem_rd == rs)) begin
			sel = FWD_MEM;
		end else if (wb_hit_en && (wb_rd == rs)) begin
			sel = FWD_WB;
		end
		return sel;
	endfunction

	always_comb begin
		fwd_a_o = pick_src(rs1_i, mem_live, mem.rd, wb_live, rd_wb_i);
		fwd_b_o = pick_src(rs2_i, mem_live, mem.rd, wb_live, rd_wb_i);
	end

endmodule

// ==== logic/alu.sv ====
`include "rv_ex_cfg.svh"

module alu (
	input rv_ex_pkg::word_t a_i,
	input rv_ex_pkg::word_t b_i,
	input rv_ex_pkg::alu_op_e op_i,
	output rv_ex_pkg::word_t result_o
);
	import rv_ex_pkg::*;

	logic [4:0] shamt;
	logic lt_s;
	logic lt_u;

	// only the low five bits shift on RV32
	assign shamt = b_i[4:0];

	assign lt_s = $signed(a_i) < $signed(b_i);
	assign lt_u = a_i < b_i;

	always_comb begin
		unique case (op_i)
			ALU_ADD: begin
				result_o = a_i + b_i;
			end
			ALU_SUB: begin
				result_o = a_i - b_i;
			end
			ALU_SLL: begin
				result_o = a_i << shamt;
			end
			ALU_SLT: begin
				result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
			end
			ALU_SLTU: begin
				result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
			end
			ALU_XOR: begin
				result_o = a_i ^ b_i;
			end
			ALU_SRL: begin
				result_o = a_i >> shamt;
			end
			ALU_SRA: begin
				result_o = word_t'($signed(a_i) >>> shamt);
			end
			ALU_OR: begin
				result_o = a_i | b_i;
			end
			ALU_AND: begin
				result_o = a_i & b_i;
			end
			// lui and csrrw
			ALU_PASSB: begin
				result_o = b_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

// ==== logic/csr_bank.sv ====
`include "rv_ex_cfg.svh"

module csr_bank (
	input logic clk_i,
	input logic rst_ni,
	input rv_ex_pkg::csr_addr_t raddr_i,
	output rv_ex_pkg::word_t rdata_o,
	ex_mem_if.csr mem
);
	import rv_ex_pkg::*;

	localparam int IDX_W = $clog2(`RV_CSR_COUNT);

	word_t csr_q [`RV_CSR_COUNT];
	logic [IDX_W-1:0] widx;
	logic [IDX_W-1:0] ridx;

	// upper address bits are don't care
	assign widx = mem.csr_addr[IDX_W-1:0];
	assign ridx = raddr_i[IDX_W-1:0];

	// --------------------
	// commit from MEM
	// --------------------
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 0; i < `RV_CSR_COUNT; i++) begin
				csr_q[i] <= '0;
			end
		end else if (mem.csr_we) begin
			csr_q[widx] <= mem.alu;
		end
	end

	// --------------------
	// read in EX
	// --------------------
	// no bypass, a write in MEM shows up after the edge
	assign rdata_o = csr_q[ridx];

endmodule

// ==== logic/ex_stage.sv ====
module ex_stage (
	input logic clk_i,
	input logic rst_ni,
	input logic enable_i,
	input logic flush_i,
	input rv_ex_pkg::word_t rs1_data_i,
	input rv_ex_pkg::word_t rs2_data_i,
	input rv_ex_pkg::word_t imm_i,
	input rv_ex_pkg::word_t pc_i,
	input rv_ex_pkg::word_t pc4_i,
	input rv_ex_pkg::reg_addr_t rd_i,
	input rv_ex_pkg::alu_op_e alu_op_i,
	input logic a_sel_pc_i,
	input logic b_sel_imm_i,
	input logic b_sel_csr_i,
	input logic br_un_i,
	input logic mem_we_i,
	input logic reg_we_i,
	input logic csr_we_i,
	input rv_ex_pkg::wb_sel_e wb_sel_i,
	input rv_ex_pkg::csr_addr_t csr_addr_i,
	input rv_ex_pkg::word_t csr_rdata_i,
	input rv_ex_pkg::word_t data_wb_i,
	input rv_ex_pkg::fwd_sel_e fwd_a_i,
	input rv_ex_pkg::fwd_sel_e fwd_b_i,
	output rv_ex_pkg::word_t alu_o,
	output logic br_eq_o,
	output logic br_lt_o,
	ex_mem_if.stage mem
);
	import rv_ex_pkg::*;

	word_t rs1_fwd;
	word_t rs2_fwd;
	word_t op_a;
	word_t op_b;
	word_t alu_res;

	function automatic word_t fwd_mux(
		input fwd_sel_e sel,
		input word_t reg_val,
		input word_t mem_val,
		input word_t wb_val
	);
		word_t val;
		case (sel)
			FWD_MEM: val = mem_val;
			FWD_WB: val = wb_val;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	// --------------------
	// operand select
	// --------------------
	assign rs1_fwd = fwd_mux(fwd_a_i, rs1_data_i, mem.alu, data_wb_i);
	assign rs2_fwd = fwd_mux(fwd_b_i, rs2_data_i, mem.alu, data_wb_i);

	assign op_a = a_sel_pc_i ? pc_i : rs1_fwd;

	// csr value wins over reg and imm
	always_comb begin
		if (b_sel_csr_i) begin
			op_b = csr_rdata_i;
		end else if (b_sel_imm_i) begin
			op_b = imm_i;
		end else begin
			op_b = rs2_fwd;
		end
	end

	alu u_alu (
		.a_i(op_a),
		.b_i(op_b),
		.op_i(alu_op_i),
		.result_o(alu_res)
	);

	assign alu_o = alu_res;

	// branch compare on forwarded regs
	assign br_eq_o = (rs1_fwd == rs2_fwd);
	assign br_lt_o = br_un_i ? (rs1_fwd < rs2_fwd) : ($signed(rs1_fwd) < $signed(rs2_fwd));

	// --------------------
	// EX/MEM register
	// --------------------
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mem.alu <= '0;
			mem.rs2 <= '0;
			mem.pc4 <= '0;
			mem.mem_we <= 1'b0;
			mem.wb_sel <= WB_MEM;
			mem.reg_we <= 1'b0;
			mem.rd <= '0;
			mem.csr_we <= 1'b0;
			mem.csr_addr <= '0;
			mem.csr_rdata <= '0;
		end else if (enable_i) begin
			if (flush_i) begin
				// bubble, WB_MEM encodes as zero
				mem.alu <= '0;
				mem.rs2 <= '0;
				mem.pc4 <= '0;
				mem.mem_we <= 1'b0;
				mem.wb_sel <= WB_MEM;
				mem.reg_we <= 1'b0;
				mem.rd <= '0;
				mem.csr_we <= 1'b0;
				mem.csr_addr <= '0;
				mem.csr_rdata <= '0;
			end else begin
				mem.alu <= alu_res;
				mem.rs2 <= rs2_fwd;
				mem.pc4 <= pc4_i;
				mem.mem_we <= mem_we_i;
				mem.wb_sel <= wb_sel_i;
				mem.reg_we <= reg_we_i;
				mem.rd <= rd_i;
				mem.csr_we <= csr_we_i;
				mem.csr_addr <= csr_addr_i;
				mem.csr_rdata <= csr_rdata_i;
			end
		end
	end

endmodule

// ==== logic/ex_top.sv ====
module ex_top (
	input logic clk_i,
	input logic rst_ni,
	input logic enable_i,
	input logic flush_i,
	input rv_ex_pkg::word_t rs1_data_i,
	input rv_ex_pkg::word_t rs2_data_i,
	input rv_ex_pkg::word_t imm_i,
	input rv_ex_pkg::word_t pc_i,
	input rv_ex_pkg::word_t pc4_i,
	input rv_ex_pkg::reg_addr_t rd_i,
	input rv_ex_pkg::alu_op_e alu_op_i,
	input logic a_sel_pc_i,
	input logic b_sel_imm_i,
	input logic b_sel_csr_i,
	input logic br_un_i,
	input logic mem_we_i,
	input logic reg_we_i,
	input logic csr_we_i,
	input rv_ex_pkg::wb_sel_e wb_sel_i,
	input rv_ex_pkg::csr_addr_t csr_addr_i,
	input rv_ex_pkg::word_t data_wb_i,
	input rv_ex_pkg::reg_addr_t rs1_i,
	input rv_ex_pkg::reg_addr_t rs2_i,
	input rv_ex_pkg::reg_addr_t rd_wb_i,
	input logic reg_we_wb_i,
	output rv_ex_pkg::word_t alu_o,
	output logic br_eq_o,
	output logic br_lt_o,
	output rv_ex_pkg::word_t alu_mem_o,
	output rv_ex_pkg::word_t rs2_mem_o,
	output rv_ex_pkg::word_t pc4_mem_o,
	output logic mem_we_mem_o,
	output logic reg_we_mem_o,
	output logic csr_we_mem_o,
	output rv_ex_pkg::wb_sel_e wb_sel_mem_o,
	output rv_ex_pkg::reg_addr_t rd_mem_o,
	output rv_ex_pkg::csr_addr_t csr_addr_mem_o,
	output rv_ex_pkg::word_t csr_rdata_mem_o
);
	import rv_ex_pkg::*;

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	word_t csr_rdata_ex;

	ex_mem_if ex_mem ();

	forward_unit u_fwd (
		.rs1_i(rs1_i),
		.rs2_i(rs2_i),
		.mem(ex_mem.fwd),
		.rd_wb_i(rd_wb_i),
		.reg_we_wb_i(reg_we_wb_i),
		.fwd_a_o(fwd_a),
		.fwd_b_o(fwd_b)
	);

	csr_bank u_csr (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.raddr_i(csr_addr_i),
		.rdata_o(csr_rdata_ex),
		.mem(ex_mem.csr)
	);

	ex_stage u_ex (
		.clk_i(clk_i),
		.rst_ni(rst_ni),
		.enable_i(enable_i),
		.flush_i(flush_i),
		.rs1_data_i(rs1_data_i),
		.rs2_data_i(rs2_data_i),
		.imm_i(imm_i),
		.pc_i(pc_i),
		.pc4_i(pc4_i),
		.rd_i(rd_i),
		.alu_op_i(alu_op_i),
		.a_sel_pc_i(a_sel_pc_i),
		.b_sel_imm_i(b_sel_imm_i),
		.b_sel_csr_i(b_sel_csr_i),
		.br_un_i(br_un_i),
		.mem_we_i(mem_we_i),
		.reg_we_i(reg_we_i),
		.csr_we_i(csr_we_i),
		.wb_sel_i(wb_sel_i),
		.csr_addr_i(csr_addr_i),
		.csr_rdata_i(csr_rdata_ex),
		.data_wb_i(data_wb_i),
		.fwd_a_i(fwd_a),
		.fwd_b_i(fwd_b),
		.alu_o(alu_o),
		.br_eq_o(br_eq_o),
		.br_lt_o(br_lt_o),
		.mem(ex_mem.stage)
	);

	// EX/MEM contents out to the MEM stage
	assign alu_mem_o = ex_mem.alu;
	assign rs2_mem_o = ex_mem.rs2;
	assign pc4_mem_o = ex_mem.pc4;
	assign mem_we_mem_o = ex_mem.mem_we;
	assign reg_we_mem_o = ex_mem.reg_we;
	assign csr_we_mem_o = ex_mem.csr_we;
	assign wb_sel_mem_o = ex_mem.wb_sel;
	assign rd_mem_o = ex_mem.rd;
	assign csr_addr_mem_o = ex_mem.csr_addr;
	assign csr_rdata_mem_o = ex_mem.csr_rdata;

endmodule

// ==== test/ex_props.sv ====
`include "rv_ex_cfg.svh"

module ex_props (
	input logic clk_i, rst_ni, enable_i, flush_i,
	input rv_ex_pkg::word_t rs1_data_i, rs2_data_i, imm_i, pc_i, pc4_i, data_wb_i,
	input rv_ex_pkg::reg_addr_t rd_i, rs1_i, rs2_i, rd_wb_i,
	input rv_ex_pkg::alu_op_e alu_op_i,
	input logic a_sel_pc_i, b_sel_imm_i, b_sel_csr_i, br_un_i,
	input logic mem_we_i, reg_we_i, csr_we_i, reg_we_wb_i,
	input rv_ex_pkg::wb_sel_e wb_sel_i,
	input rv_ex_pkg::csr_addr_t csr_addr_i,
	input rv_ex_pkg::word_t alu_o, alu_mem_o, rs2_mem_o, pc4_mem_o, csr_rdata_mem_o,
	input logic br_eq_o, br_lt_o, mem_we_mem_o, reg_we_mem_o, csr_we_mem_o,
	input rv_ex_pkg::wb_sel_e wb_sel_mem_o,
	input rv_ex_pkg::reg_addr_t rd_mem_o,
	input rv_ex_pkg::csr_addr_t csr_addr_mem_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import rv_ex_pkg::*;

	localparam word_t SIGN_BIT = {1'b1, {(`RV_XLEN-1){1'b0}}};

	typedef struct packed {
		word_t alu;
		word_t rs2;
		word_t pc4;
		logic mem_we;
		wb_sel_e wb_sel;
		logic reg_we;
		reg_addr_t rd;
		logic csr_we;
		csr_addr_t csr_addr;
		word_t csr_rdata;
	} ex_mem_t;

	int fail_cnt = 0;
	string fail_what = "";
	time fail_at = 0;

	logic rst_seen;
	word_t csr_ref [`RV_CSR_COUNT];
	word_t src1;
	word_t src2;
	word_t op_a;
	word_t op_b;
	ex_mem_t exp_d;
	ex_mem_t exp_q;
	ex_mem_t seen;

	task automatic note_fail(input string what);
		fail_cnt++;
		fail_what = what;
		fail_at = $time;
		$error("%s", what);
	endtask

	// flipping the sign bit turns a signed compare into an unsigned one
	function automatic logic lt_signed(input word_t a, input word_t b);
		return (a ^ SIGN_BIT) < (b ^ SIGN_BIT);
	endfunction

	// MEM result beats WB and x0 is never forwarded
	function automatic word_t fwd_value(input reg_addr_t rs, input word_t reg_val);
		if (rs == '0) begin
			return reg_val;
		end
		if (reg_we_mem_o && (rd_mem_o == rs)) begin
			return alu_mem_o;
		end
		if (reg_we_wb_i && (rd_wb_i == rs)) begin
			return data_wb_i;
		end
		return reg_val;
	endfunction

	function automatic word_t ref_alu(input word_t a, input word_t b, input alu_op_e op);
		logic [2*`RV_XLEN-1:0] ext;
		int sh;
		sh = b % `RV_XLEN;
		ext = {{`RV_XLEN{a[`RV_XLEN-1]}}, a} >> sh;
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a + ~b + 1'b1;
			ALU_SLL: return a << sh;
			ALU_SLT: return word_t'(lt_signed(a, b));
			ALU_SLTU: return word_t'(a < b);
			ALU_XOR: return a ^ b;
			ALU_SRL: return a >> sh;
			ALU_SRA: return ext[`RV_XLEN-1:0];
			ALU_OR: return a | b;
			ALU_AND: return a & b;
			ALU_PASSB: return b;
			default: return '0;
		endcase
	endfunction

	// --------------------
	// reference model
	// --------------------
	always_comb begin
		src1 = fwd_value(rs1_i, rs1_data_i);
		src2 = fwd_value(rs2_i, rs2_data_i);
		op_a = a_sel_pc_i ? pc_i : src1;
		if (b_sel_csr_i) begin
			op_b = csr_ref[csr_addr_i % `RV_CSR_COUNT];
		end else begin
			op_b = b_sel_imm_i ? imm_i : src2;
		end
		exp_d.alu = ref_alu(op_a, op_b, alu_op_i);
		exp_d.rs2 = src2;
		exp_d.pc4 = pc4_i;
		exp_d.mem_we = mem_we_i;
		exp_d.wb_sel = wb_sel_i;
		exp_d.reg_we = reg_we_i;
		exp_d.rd = rd_i;
		exp_d.csr_we = csr_we_i;
		exp_d.csr_addr = csr_addr_i;
		exp_d.csr_rdata = csr_ref[csr_addr_i % `RV_CSR_COUNT];
	end

	assign seen = {alu_mem_o, rs2_mem_o, pc4_mem_o, mem_we_mem_o, wb_sel_mem_o,
		reg_we_mem_o, rd_mem_o, csr_we_mem_o, csr_addr_mem_o, csr_rdata_mem_o};

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rst_seen <= 1'b0;
			exp_q <= '0;
			for (int i = 0; i < `RV_CSR_COUNT; i++) begin
				csr_ref[i] <= '0;
			end
		end else begin
			rst_seen <= 1'b1;
			// csr commit from the MEM side
			if (csr_we_mem_o) begin
				csr_ref[csr_addr_mem_o % `RV_CSR_COUNT] <= alu_mem_o;
			end
			if (enable_i) begin
				exp_q <= flush_i ? '0 : exp_d;
			end
		end
	end

	// --------------------
	// checks
	// --------------------
	a_we_reset: assert property (@(posedge clk_i)
		!rst_seen |-> !mem_we_mem_o && !reg_we_mem_o && !csr_we_mem_o)
		else note_fail("write enable high in or right after reset");

	a_alu_comb: assert property (@(posedge clk_i) disable iff (!rst_ni)
		alu_o == ref_alu(op_a, op_b, alu_op_i))
		else note_fail("combinational ALU result");

	a_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(br_eq_o == (src1 == src2)) &&
		(br_lt_o == (br_un_i ? (src1 < src2) : lt_signed(src1, src2))))
		else note_fail("branch compare");

	a_alu_mem: assert property (@(posedge clk_i) disable iff (!rst_ni)
		seen.alu == exp_q.alu)
		else note_fail("ALU result in EX/MEM");

	a_csr_mem: assert property (@(posedge clk_i) disable iff (!rst_ni)
		seen.csr_rdata == exp_q.csr_rdata)
		else note_fail("CSR read data in EX/MEM");

	a_fields_mem: assert property (@(posedge clk_i) disable iff (!rst_ni)
		{seen.rs2, seen.pc4, seen.mem_we, seen.wb_sel, seen.reg_we, seen.rd,
			seen.csr_we, seen.csr_addr} ==
		{exp_q.rs2, exp_q.pc4, exp_q.mem_we, exp_q.wb_sel, exp_q.reg_we, exp_q.rd,
			exp_q.csr_we, exp_q.csr_addr})
		else note_fail("store data, pc4 or control field in EX/MEM");

	a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!enable_i |=> $stable(seen))
		else note_fail("EX/MEM changed while stalled");

	a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
		enable_i && flush_i |=> seen == '0)
		else note_fail("EX/MEM not cleared by flush");

endmodule

// ==== test/ex_tb.sv ====
module ex_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rv_ex_pkg::*;

	localparam int DRV_DLY = 5;
	localparam int WAIT_LIMIT = 20;

	logic clk_i, rst_ni, enable_i, flush_i;
	word_t rs1_data_i, rs2_data_i, imm_i, pc_i, pc4_i, data_wb_i;
	reg_addr_t rd_i, rs1_i, rs2_i, rd_wb_i;
	alu_op_e alu_op_i;
	logic a_sel_pc_i, b_sel_imm_i, b_sel_csr_i, br_un_i;
	logic mem_we_i, reg_we_i, csr_we_i, reg_we_wb_i;
	wb_sel_e wb_sel_i;
	csr_addr_t csr_addr_i;
	word_t alu_o, alu_mem_o, rs2_mem_o, pc4_mem_o, csr_rdata_mem_o;
	logic br_eq_o, br_lt_o, mem_we_mem_o, reg_we_mem_o, csr_we_mem_o;
	wb_sel_e wb_sel_mem_o;
	reg_addr_t rd_mem_o;
	csr_addr_t csr_addr_mem_o;

	logic [31:0] lfsr_state;
	word_t pc_q;

	ex_top UUT (.*);

	bind ex_top ex_props u_props (.*);

	always #50 clk_i = ~clk_i;

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	// any assertion failure ends the run at the next falling edge
	always @(negedge clk_i) begin
		if (UUT.u_props.fail_cnt != 0) begin
			fail_stop($sformatf("MISMATCH at %0t: %s", UUT.u_props.fail_at,
				UUT.u_props.fail_what));
		end
	end

	// --------------------
	// stimulus source
	// --------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'hA300_0000;
		end
		return n;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic rand_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
		return b;
	endfunction

	task automatic clear_inputs();
		rst_ni = 1'b0;
		enable_i = 1'b0;
		flush_i = 1'b0;
		rs1_data_i = '0;
		rs2_data_i = '0;
		imm_i = '0;
		pc_i = '0;
		pc4_i = '0;
		data_wb_i = '0;
		rd_i = '0;
		rs1_i = '0;
		rs2_i = '0;
		rd_wb_i = '0;
		alu_op_i = ALU_ADD;
		a_sel_pc_i = 1'b0;
		b_sel_imm_i = 1'b0;
		b_sel_csr_i = 1'b0;
		br_un_i = 1'b0;
		mem_we_i = 1'b0;
		reg_we_i = 1'b0;
		csr_we_i = 1'b0;
		reg_we_wb_i = 1'b0;
		wb_sel_i = WB_MEM;
		csr_addr_i = '0;
	endtask

	// one instruction into EX, small register range when hazards are wanted
	task automatic issue(input alu_op_e op, input logic hazards);
		rs1_data_i = rand_bits(32);
		rs2_data_i = rand_bits(32);
		imm_i = rand_bits(32);
		data_wb_i = rand_bits(32);
		alu_op_i = op;
		a_sel_pc_i = rand_bit();
		b_sel_imm_i = rand_bit();
		b_sel_csr_i = (rand_bits(2) == 0);
		br_un_i = rand_bit();
		mem_we_i = rand_bit();
		wb_sel_i = wb_sel_e'(rand_bits(2));
		csr_we_i = 1'b0;
		csr_addr_i = csr_addr_t'(rand_bits(12));
		if (hazards) begin
			rs1_i = reg_addr_t'(rand_bits(2));
			rs2_i = reg_addr_t'(rand_bits(2));
			rd_i = reg_addr_t'(rand_bits(2));
			rd_wb_i = reg_addr_t'(rand_bits(2));
			reg_we_i = (rand_bits(2) != 0);
			reg_we_wb_i = rand_bit();
		end else begin
			rs1_i = reg_addr_t'(rand_bits(5));
			rs2_i = reg_addr_t'(rand_bits(5));
			rd_i = reg_addr_t'(rand_bits(5));
			rd_wb_i = reg_addr_t'(rand_bits(5));
			reg_we_i = 1'b0;
			reg_we_wb_i = 1'b0;
		end
		pc_i = pc_q;
		pc4_i = pc_q + 4;
		pc_q = pc_q + 4;
		enable_i = 1'b1;
		flush_i = 1'b0;
	endtask

	// a pc4 of zero means a bubble reached MEM
	task automatic wait_pc4_mem(input word_t pc4);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk_i);
			#DRV_DLY;
			cycles++;
		end while ((pc4_mem_o != pc4) && (cycles < WAIT_LIMIT));
		if (pc4_mem_o != pc4) begin
			fail_stop($sformatf("timeout at %0t: pc4 %h never reached the EX/MEM register",
				$time, pc4));
		end
	endtask

	task automatic csr_round(input logic [1:0] idx);
		issue(ALU_PASSB, 1'b0);
		b_sel_imm_i = 1'b1;
		b_sel_csr_i = 1'b0;
		csr_we_i = 1'b1;
		csr_addr_i = csr_addr_t'({rand_bits(10), idx});
		wait_pc4_mem(pc4_i);
		// bubble lets the write commit before the read
		flush_i = 1'b1;
		wait_pc4_mem(32'h0);
		issue(ALU_PASSB, 1'b0);
		b_sel_csr_i = 1'b1;
		csr_addr_i = csr_addr_t'({rand_bits(10), idx});
		wait_pc4_mem(pc4_i);
	endtask

	initial begin
		clk_i = 1'b0;
		clear_inputs();
		lfsr_state = 32'd81213;
		pc_q = 32'h0000_1000;
		repeat (8) @(posedge clk_i);
		#DRV_DLY;
		rst_ni = 1'b1;

		// every ALU op without hazards
		for (int k = 0; k < 11; k++) begin
			for (int n = 0; n < 6; n++) begin
				issue(alu_op_e'(k), 1'b0);
				wait_pc4_mem(pc4_i);
			end
		end

		// back to back on few registers
		for (int n = 0; n < 80; n++) begin
			issue(alu_op_e'(rand_bits(4) % 11), 1'b1);
			wait_pc4_mem(pc4_i);
		end

		// stall, then flush
		for (int n = 0; n < 6; n++) begin
			issue(alu_op_e'(rand_bits(4) % 11), 1'b1);
			wait_pc4_mem(pc4_i);
			issue(alu_op_e'(rand_bits(4) % 11), 1'b1);
			enable_i = 1'b0;
			flush_i = rand_bit();
			repeat (3) begin
				@(posedge clk_i);
				#DRV_DLY;
			end
			enable_i = 1'b1;
			flush_i = 1'b1;
			wait_pc4_mem(32'h0);
		end

		for (int idx = 0; idx < 4; idx++) begin
			csr_round(idx[1:0]);
		end

		repeat (2) begin
			@(posedge clk_i);
			#DRV_DLY;
		end
		if (UUT.u_props.fail_cnt == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			fail_stop("assertion failures were counted during the run");
		end
	end

endmodule

// ==== rv_ex.f ====
+incdir+logic
logic/rv_ex_pkg.sv
logic/ex_mem_if.sv
logic/forward_unit.sv
logic/alu.sv
logic/csr_bank.sv
logic/ex_stage.sv
logic/ex_top.sv
test/ex_props.sv
test/ex_tb.sv
